/* src/aes_pkg.sv */
package aes_pkg;

	localparam int NR = 10;
	localparam int KEY_RAM_DEPTH = 16;

	typedef logic [127:0] block_t;
	typedef logic [127:0] key_t;
	typedef logic [31:0]  word_t;
	typedef logic [3:0]   round_idx_t;  // also the key RAM address

	typedef enum logic [1:0] {ST_IDLE, ST_KEY_EXP, ST_CIPHER, ST_DONE} aes_state_t;

	typedef struct packed {
		logic       we;
		round_idx_t addr;
		key_t       data;
	} rk_write_t;

	typedef struct packed {
		logic step;
		logic first;        // initial AddRoundKey only
		logic final_round;  // round without MixColumns
	} round_ctl_t;

	function automatic logic [7:0] xtime(input logic [7:0] b);
		return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
	endfunction

	function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
		logic [7:0] p;
		logic [7:0] t;
		p = 8'h00;
		t = a;
		for (int i = 0; i < 8; i++) begin
			if (b[i])
				p = p ^ t;
			t = xtime(t);
		end
		return p;
	endfunction

	// inverse as x^254 = x^2 * x^4 * ... * x^128, then the affine map
	function automatic logic [7:0] sbox_byte(input logic [7:0] x);
		logic [7:0] sq;
		logic [7:0] inv;
		sq = x;
		inv = 8'h01;
		for (int i = 1; i < 8; i++) begin
			sq = gf_mul(sq, sq);
			inv = gf_mul(inv, sq);
		end
		return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]} ^ {inv[4:0], inv[7:5]}
			^ {inv[3:0], inv[7:4]} ^ 8'h63;
	endfunction

	function automatic word_t sub_word(input word_t w);
		word_t o;
		for (int i = 0; i < 4; i++)
			o[8*i +: 8] = sbox_byte(w[8*i +: 8]);
		return o;
	endfunction

	function automatic word_t rot_word(input word_t w);
		return {w[23:0], w[31:24]};
	endfunction

	function automatic block_t sub_bytes(input block_t s);
		block_t o;
		for (int i = 0; i < 16; i++)
			o[8*i +: 8] = sbox_byte(s[8*i +: 8]);
		return o;
	endfunction

	// byte 4*c+r sits at column c, row r, first byte in the msbs
	function automatic block_t shift_rows(input block_t s);
		block_t o;
		for (int c = 0; c < 4; c++)
			for (int r = 0; r < 4; r++)
				o[127-8*(4*c+r) -: 8] = s[127-8*(4*((c+r)%4)+r) -: 8];
		return o;
	endfunction

	function automatic block_t mix_columns(input block_t s);
		block_t     o;
		logic [7:0] a0;
		logic [7:0] a1;
		logic [7:0] a2;
		logic [7:0] a3;
		for (int c = 0; c < 4; c++) begin
			a0 = s[127-32*c -: 8];
			a1 = s[119-32*c -: 8];
			a2 = s[111-32*c -: 8];
			a3 = s[103-32*c -: 8];
			o[127-32*c -: 8] = xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3;
			o[119-32*c -: 8] = a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3;
			o[111-32*c -: 8] = a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3;
			o[103-32*c -: 8] = xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3);
		end
		return o;
	endfunction

	function automatic logic [7:0] rcon(input round_idx_t i);
		case (i)
			4'd1:    return 8'h01;
			4'd2:    return 8'h02;
			4'd3:    return 8'h04;
			4'd4:    return 8'h08;
			4'd5:    return 8'h10;
			4'd6:    return 8'h20;
			4'd7:    return 8'h40;
			4'd8:    return 8'h80;
			4'd9:    return 8'h1b;
			4'd10:   return 8'h36;
			default: return 8'h00;
		endcase
	endfunction

endpackage

/* src/aes_ctrl.sv */
`timescale 1ns/1ns

module aes_ctrl
	import aes_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       en,
	input  logic       cipher_mode,
	input  logic       key_exp_mode,
	input  logic       last_round,
	output logic       cnt_clear,
	output logic       cnt_step,
	output logic       kx_load,
	output logic       kx_step,
	output round_ctl_t round_ctl,
	output logic       key_exp_active,
	output logic       busy,
	output logic       done
);

	aes_state_t state;
	logic       accept;

	assign accept = (state == ST_IDLE) && en && (key_exp_mode || cipher_mode);

	assign cnt_clear = accept;
	assign cnt_step = (state == ST_KEY_EXP || state == ST_CIPHER) && !last_round;
	assign kx_load = accept && key_exp_mode;  // key expansion wins over cipher
	assign kx_step = (state == ST_KEY_EXP);
	assign key_exp_active = (state == ST_KEY_EXP);
	assign done = (state == ST_DONE);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE:
					if (accept)
						state <= key_exp_mode ? ST_KEY_EXP : ST_CIPHER;
				ST_KEY_EXP:
					if (last_round)
						state <= ST_DONE;
				ST_CIPHER:
					if (round_ctl.final_round)  // last round applied this cycle
						state <= ST_DONE;
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	// round control trails the RAM address by one cycle to meet the read data
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			round_ctl <= '0;
			busy <= 1'b0;
		end else begin
			round_ctl.step <= (state == ST_CIPHER) && !round_ctl.final_round;
			round_ctl.first <= (state == ST_CIPHER) && !round_ctl.step;
			round_ctl.final_round <= (state == ST_CIPHER) && last_round && !round_ctl.final_round;
			if (accept)
				busy <= 1'b1;
			else if (state == ST_DONE)
				busy <= 1'b0;
		end
	end

	a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		done |=> (!done && !busy));
	a_idle_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
		(state == ST_IDLE) |-> !busy);

endmodule

/* src/round_counter.sv */
`timescale 1ns/1ns

module round_counter
	import aes_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       clear,
	input  logic       step,
	output round_idx_t round_idx,
	output logic       last_round
);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			round_idx <= '0;
		else if (clear)
			round_idx <= '0;
		else if (step)
			round_idx <= round_idx + 4'd1;
	end

	assign last_round = (round_idx == round_idx_t'(NR));

	a_idx_range: assert property (@(posedge clk) disable iff (!rst_n)
		round_idx <= round_idx_t'(NR));

endmodule

/* src/key_expander.sv */
`timescale 1ns/1ns

module key_expander
	import aes_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      load,
	input  logic      step,
	input  key_t      key,
	output rk_write_t rk_write
);

	key_t       cur_key;
	round_idx_t rnd;       // round number of cur_key
	round_idx_t rnd_next;
	word_t      tmp;
	word_t      w0;
	word_t      w1;
	word_t      w2;
	word_t      w3;

	assign rnd_next = rnd + 4'd1;
	assign tmp = sub_word(rot_word(cur_key[31:0])) ^ {rcon(rnd_next), 24'h000000};
	assign w0 = cur_key[127:96] ^ tmp;
	assign w1 = cur_key[95:64] ^ w0;
	assign w2 = cur_key[63:32] ^ w1;
	assign w3 = cur_key[31:0] ^ w2;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			rnd <= '0;
		else if (load)
			rnd <= '0;
		else if (step)
			rnd <= rnd_next;
	end

	always_ff @(posedge clk) begin
		if (load)
			cur_key <= key;
		else if (step)
			cur_key <= {w0, w1, w2, w3};
	end

	assign rk_write = '{we: step, addr: rnd, data: cur_key};  // write before advancing

endmodule

/* src/round_key_ram.sv */
`timescale 1ns/1ns

module round_key_ram
	import aes_pkg::*;
(
	input  logic       clk,
	input  round_idx_t addr,
	input  rk_write_t  wr,
	output key_t       rd_data
);

	key_t mem [KEY_RAM_DEPTH];

	always_ff @(posedge clk) begin
		if (wr.we)
			mem[addr] <= wr.data;
		rd_data <= mem[addr];  // read first on a write cycle
	end

	// only round keys 0..NR are ever stored
	a_wr_range: assert property (@(posedge clk) wr.we |-> addr <= round_idx_t'(NR));

endmodule

/* src/cipher_datapath.sv */
`timescale 1ns/1ns

module cipher_datapath
	import aes_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       load,
	input  block_t     in_blk,
	input  key_t       round_key,
	input  round_ctl_t round_ctl,
	output block_t     out_blk
);

	block_t sb;
	block_t sr;
	block_t mc;

	assign sb = sub_bytes(out_blk);
	assign sr = shift_rows(sb);
	assign mc = mix_columns(sr);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_blk <= '0;
		end else if (load) begin
			out_blk <= in_blk;
		end else if (round_ctl.step) begin
			if (round_ctl.first)
				out_blk <= out_blk ^ round_key;
			else if (round_ctl.final_round)
				out_blk <= sr ^ round_key;  // no MixColumns in the last round
			else
				out_blk <= mc ^ round_key;
		end
	end

endmodule

/* src/aes_top.sv */
`timescale 1ns/1ns

module aes_top
	import aes_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,
	input  logic   en,
	input  logic   cipher_mode,
	input  logic   key_exp_mode,
	input  key_t   aes_key,
	input  block_t aes_in_blk,
	output block_t aes_out_blk,
	output logic   aes_op_in_progress,
	output logic   en_o
);

	logic       cnt_clear;
	logic       cnt_step;
	logic       kx_load;
	logic       kx_step;
	logic       key_exp_active;
	logic       last_round;
	logic       cipher_load;
	round_ctl_t round_ctl;
	round_idx_t round_idx;
	round_idx_t ram_addr;
	rk_write_t  rk_write;
	key_t       round_key;

	// accepted command that is not a key expansion starts the cipher
	assign cipher_load = cnt_clear && !kx_load;

	assign ram_addr = key_exp_active ? rk_write.addr : round_idx;

	aes_ctrl u_ctrl (
		.clk            (clk),
		.rst_n          (rst_n),
		.en             (en),
		.cipher_mode    (cipher_mode),
		.key_exp_mode   (key_exp_mode),
		.last_round     (last_round),
		.cnt_clear      (cnt_clear),
		.cnt_step       (cnt_step),
		.kx_load        (kx_load),
		.kx_step        (kx_step),
		.round_ctl      (round_ctl),
		.key_exp_active (key_exp_active),
		.busy           (aes_op_in_progress),
		.done           (en_o)
	);

	round_counter u_cnt (
		.clk        (clk),
		.rst_n      (rst_n),
		.clear      (cnt_clear),
		.step       (cnt_step),
		.round_idx  (round_idx),
		.last_round (last_round)
	);

	key_expander u_kx (
		.clk      (clk),
		.rst_n    (rst_n),
		.load     (kx_load),
		.step     (kx_step),
		.key      (aes_key),
		.rk_write (rk_write)
	);

	round_key_ram u_ram (
		.clk     (clk),
		.addr    (ram_addr),
		.wr      (rk_write),
		.rd_data (round_key)
	);

	cipher_datapath u_dp (
		.clk       (clk),
		.rst_n     (rst_n),
		.load      (cipher_load),
		.in_blk    (aes_in_blk),
		.round_key (round_key),
		.round_ctl (round_ctl),
		.out_blk   (aes_out_blk)
	);

endmodule

/* verification/aes_top_tb.sv */
`timescale 1ns/1ns

module aes_top_tb
	import aes_pkg::*;
();

	localparam key_t   KEY1 = 128'h2b7e151628aed2a6abf7158809cf4f3c;
	localparam block_t PT1 = 128'h3243f6a8885a308d313198a2e0370734;
	localparam block_t CT1 = 128'h3925841d02dc09fbdc118597196a0b32;
	localparam key_t   KEY2 = 128'h000102030405060708090a0b0c0d0e0f;
	localparam block_t PT2 = 128'h00112233445566778899aabbccddeeff;
	localparam block_t CT2 = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
	localparam int     KX_LAT = 12;
	localparam int     CI_LAT = 13;
	localparam int     DONE_TIMEOUT = 40;

	logic   clk;
	logic   rst_n;
	logic   en;
	logic   cipher_mode;
	logic   key_exp_mode;
	key_t   aes_key;
	block_t aes_in_blk;
	block_t aes_out_blk;
	logic   aes_op_in_progress;
	logic   en_o;

	integer seed = 32'h8a6d1411;
	string  test_name = "reset";
	int     assert_errs = 0;
	int     seq_errs = 0;

	// expected command timing
	logic   run;
	logic   is_ci;
	int     cyc;       // cycles since the accepting edge
	int     lat;
	logic   out_hold;
	block_t exp_blk;   // result of the next cipher command
	block_t run_exp;
	block_t held_blk;

	aes_top UUT (
		.clk                (clk),
		.rst_n              (rst_n),
		.en                 (en),
		.cipher_mode        (cipher_mode),
		.key_exp_mode       (key_exp_mode),
		.aes_key            (aes_key),
		.aes_in_blk         (aes_in_blk),
		.aes_out_blk        (aes_out_blk),
		.aes_op_in_progress (aes_op_in_progress),
		.en_o               (en_o)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			run <= 1'b0;
			is_ci <= 1'b0;
			cyc <= 0;
			lat <= 0;
			out_hold <= 1'b1;  // output must read zero after reset
			held_blk <= '0;
			run_exp <= '0;
		end else if (!run) begin
			if (en && (key_exp_mode || cipher_mode)) begin
				run <= 1'b1;
				cyc <= 1;
				lat <= key_exp_mode ? KX_LAT : CI_LAT;  // key expansion wins
				is_ci <= !key_exp_mode;
				if (!key_exp_mode) begin
					out_hold <= 1'b0;
					run_exp <= exp_blk;
				end
			end
		end else begin
			cyc <= cyc + 1;
			if (cyc == lat) begin
				run <= 1'b0;
				if (is_ci) begin
					out_hold <= 1'b1;
					held_blk <= run_exp;
				end
			end
		end
	end

	a_idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		!run |-> (!en_o && !aes_op_in_progress))
		else begin
			assert_errs++;
			$display("%s: en_o or busy high while no operation runs", test_name);
		end

	a_done_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		run |-> (en_o == (cyc == lat)))
		else begin
			assert_errs++;
			$display("%s: en_o wrong in cycle %0d after accept, pulse due in cycle %0d",
				test_name, $sampled(cyc), $sampled(lat));
		end

	a_busy_run: assert property (@(posedge clk) disable iff (!rst_n)
		run |-> aes_op_in_progress)
		else begin
			assert_errs++;
			$display("%s: busy low in cycle %0d of a running operation", test_name,
				$sampled(cyc));
		end

	a_cipher_out: assert property (@(posedge clk) disable iff (!rst_n)
		(run && is_ci && cyc == lat) |-> (aes_out_blk == run_exp))
		else begin
			assert_errs++;
			$display("mismatch %s expected %h actual %h", test_name, $sampled(run_exp),
				$sampled(aes_out_blk));
		end

	a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
		out_hold |-> (aes_out_blk == held_blk))
		else begin
			assert_errs++;
			$display("mismatch %s expected %h actual %h", test_name, $sampled(held_blk),
				$sampled(aes_out_blk));
		end

	// one en pulse, returns on the accepting edge
	task automatic issue_cmd(input logic kx, input logic ci, input key_t k, input block_t b);
		@(posedge clk);
		en <= 1'b1;
		key_exp_mode <= kx;
		cipher_mode <= ci;
		aes_key <= k;
		aes_in_blk <= b;
		@(posedge clk);
		en <= 1'b0;
		key_exp_mode <= 1'b0;
		cipher_mode <= 1'b0;
	endtask

	task automatic wait_done(input int limit);
		int n;
		n = 0;
		while (!en_o && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (!en_o) begin
			seq_errs++;
			$display("%s: no en_o pulse within %0d cycles", test_name, limit);
		end
	endtask

	task automatic check_no_done(input int window);
		int n;
		n = 0;
		while (!en_o && n < window) begin
			@(negedge clk);
			n++;
		end
		if (en_o) begin
			seq_errs++;
			$display("%s: en_o pulsed after a command with no mode", test_name);
		end
	endtask

	task automatic junk_during_run(input int cycles);
		logic [31:0] r;
		repeat (cycles) begin
			@(posedge clk);
			r = $random(seed);
			en <= r[0];
			cipher_mode <= r[1];
			key_exp_mode <= r[2];
			aes_in_blk <= {$random(seed), $random(seed), $random(seed), $random(seed)};
		end
		@(posedge clk);
		en <= 1'b0;
		cipher_mode <= 1'b0;
		key_exp_mode <= 1'b0;
	endtask

	task automatic idle_gap();
		int gap;
		gap = ($random(seed) & 7) + 1;
		repeat (gap) @(posedge clk);
	endtask

	initial begin
		rst_n = 1'b0;
		en = 1'b0;
		cipher_mode = 1'b0;
		key_exp_mode = 1'b0;
		aes_key = '0;
		aes_in_blk = '0;
		exp_blk = '0;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		repeat (4) @(posedge clk);

		test_name = "fips_key1";
		issue_cmd(1'b1, 1'b0, KEY1, '0);
		wait_done(DONE_TIMEOUT);
		exp_blk = CT1;
		idle_gap();
		issue_cmd(1'b0, 1'b1, '0, PT1);
		wait_done(DONE_TIMEOUT);

		test_name = "repeat_cipher";
		repeat (2) begin
			idle_gap();
			issue_cmd(1'b0, 1'b1, '0, PT1);
			wait_done(DONE_TIMEOUT);
		end

		test_name = "busy_ignore";
		idle_gap();
		issue_cmd(1'b0, 1'b1, '0, PT1);
		junk_during_run(9);  // stops well before the DUT is idle again
		wait_done(DONE_TIMEOUT);

		test_name = "both_modes";
		idle_gap();
		issue_cmd(1'b1, 1'b1, KEY1, {4{32'hdeadbeef}});
		wait_done(DONE_TIMEOUT);
		idle_gap();
		issue_cmd(1'b0, 1'b1, '0, PT1);
		wait_done(DONE_TIMEOUT);

		test_name = "no_mode";
		idle_gap();
		issue_cmd(1'b0, 1'b0, KEY2, PT2);
		check_no_done(20);

		test_name = "fips_key2";
		issue_cmd(1'b1, 1'b0, KEY2, '0);
		wait_done(DONE_TIMEOUT);
		exp_blk = CT2;
		idle_gap();
		issue_cmd(1'b0, 1'b1, '0, PT2);
		wait_done(DONE_TIMEOUT);
		repeat (4) @(posedge clk);

		$display("errors: %0d assertion, %0d sequence", assert_errs, seq_errs);
		if (assert_errs == 0 && seq_errs == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

/* build.f */
src/aes_pkg.sv
src/aes_ctrl.sv
src/round_counter.sv
src/key_expander.sv
src/round_key_ram.sv
src/cipher_datapath.sv
src/aes_top.sv
verification/aes_top_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the AES testbench with Verilator, run it and scan the log
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module aes_top_tb -o aes_top_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/aes_top_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "Verification passed" "$LOG"; then
	exit 0
fi
exit 1
